//--- Makefile
# Verilator build and run for the SPI master transmit path

VERILATOR ?= verilator
TOP       ?= spi_master_tx_tb
BUILD_DIR ?= build
FILELIST  := spi_master_tx.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, exit status gives pass or fail"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) BUILD_DIR=$(BUILD_DIR)"

test:
	$(VERILATOR) --binary --assert --timing --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/spi_master_tx.sv
`timescale 1ns/100ps
module spi_master_tx (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   emode,
   input  logic                   access_in,
   input  spi_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   output logic                   sclk,
   output logic                   mosi,
   output logic                   ss_n
);
   import spi_pkg::*;

   // ####################
   // Stage links
   // ####################

   tx_job_t       job;
   logic          job_valid;
   logic          busy;
   logic          fifo_wr;
   logic [SW-1:0] fifo_din;
   logic          prog_full;
   logic          fifo_rd;
   logic          fifo_empty;
   logic [SW-1:0] fifo_dout;
   logic          fifo_full;   // Observed by the bound checker only

   spi_tx_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .emode     (emode),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .busy      (busy),
      .job_valid (job_valid),
      .job       (job)
   );

   spi_par2ser u_par2ser (
      .clk       (clk),
      .rst       (rst),
      .job_valid (job_valid),
      .job       (job),
      .busy      (busy),
      .prog_full (prog_full),
      .fifo_wr   (fifo_wr),
      .fifo_din  (fifo_din)
   );

   spi_tx_fifo u_fifo (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (fifo_wr),
      .din       (fifo_din),
      .rd_en     (fifo_rd),
      .dout      (fifo_dout),
      .empty     (fifo_empty),
      .full      (fifo_full),
      .prog_full (prog_full)
   );

   // SPI pins
   spi_shifter u_shifter (
      .clk     (clk),
      .rst     (rst),
      .empty   (fifo_empty),
      .dout    (fifo_dout),
      .fifo_rd (fifo_rd),
      .sclk    (sclk),
      .mosi    (mosi),
      .ss_n    (ss_n)
   );

endmodule

//--- hdl/spi_par2ser.sv
`timescale 1ns/100ps
module spi_par2ser (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    job_valid,
   input  spi_pkg::tx_job_t        job,
   output logic                    busy,
   input  logic                    prog_full,   // FIFO near full, stall
   output logic                    fifo_wr,
   output logic [spi_pkg::SW-1:0]  fifo_din
);
   import spi_pkg::*;

   logic [PW-1:0]   shreg;     // Remaining bytes, next one at the bottom
   logic [CNTW-1:0] cnt;       // Bytes left minus one
   logic            load;
   logic            last;

   // ####################
   // Control
   // ####################

   assign load = job_valid & ~busy;        // Decode sees the same term
   assign last = (cnt == '0);

   // One byte per cycle unless the FIFO pushes back
   assign fifo_wr  = busy & ~prog_full;
   assign fifo_din = shreg[SW-1:0];        // Low byte goes first

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (load) begin
         busy <= 1'b1;
      end else if (fifo_wr && last) begin
         busy <= 1'b0;                     // Drop after final byte
      end
   end

   // ####################
   // Datapath
   // ####################

   // Shift right a byte per write, count down in step
   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= job.payload;
         cnt   <= job.count;
      end else if (fifo_wr) begin
         shreg <= shreg >> SW;
         cnt   <= cnt - 1'b1;
      end
   end

endmodule

//--- hdl/spi_pkg.sv
package spi_pkg;

   // ####################
   // Widths and depths
   // ####################

   localparam int AW     = 32;           // Address and data word
   localparam int PW     = 2*AW + 40;    // Full emesh packet, 104 bits
   localparam int SW     = 8;            // Serial byte
   localparam int NBYTES = PW / SW;      // 13 bytes per raw packet
   localparam int CNTW   = 4;            // Byte counter, holds NBYTES-1

   localparam int FIFO_DEPTH      = 16;
   localparam int FIFO_AW         = 4;            // Pointer width
   localparam int FIFO_CW         = FIFO_AW + 1;  // Fill count, 0..DEPTH
   localparam int PROG_FULL_LEVEL = 12;           // Headroom for bytes in flight

   // SPI timing, mode 0 only
   localparam int CLKDIV = 2;                     // clk cycles per sclk half period
   localparam int DIVW   = $clog2(CLKDIV);        // Half-period counter
   localparam int BITW   = $clog2(SW);            // Bit index in a byte

   // ####################
   // Register map
   // ####################

   // Compared against dstaddr[5:0]
   localparam logic [5:0] SPI_TX = 6'h10;

   // ####################
   // Types
   // ####################

   // Transfer size, 1 << mode bytes
   typedef enum logic [1:0] {
      DM_BYTE,
      DM_HALF,
      DM_WORD,
      DM_DOUBLE
   } datamode_e;

   // Emesh packet, MSB first; byte 0 = write, datamode, ctrlmode
   // Bit layout is also the raw-mode wire order, LSB byte first
   typedef struct packed {
      logic [AW-1:0] srcaddr;   // [103:72]
      logic [AW-1:0] data;      // [71:40]
      logic [AW-1:0] dstaddr;   // [39:8]
      logic [4:0]    ctrlmode;  // [7:3]
      logic [1:0]    datamode;  // [2:1], decoded as datamode_e
      logic          write;     // [0]
   } emesh_packet_t;

   // One transmit job from decode to serializer
   typedef struct packed {
      logic [PW-1:0]   payload;  // Byte 0 in the low bits
      logic [CNTW-1:0] count;    // Bytes minus one
   } tx_job_t;

   // SPI shifter FSM
   typedef enum logic [1:0] {
      SH_IDLE,   // ss_n high, waiting for a byte
      SH_LOW,    // sclk low half, mosi settled
      SH_HIGH,   // sclk high half, slave samples
      SH_GAP     // Hold ss_n low a half period after last fall
   } shift_state_e;

endpackage

//--- hdl/spi_shifter.sv
`timescale 1ns/100ps
module spi_shifter (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    empty,
   input  logic [spi_pkg::SW-1:0]  dout,
   output logic                    fifo_rd,
   output logic                    sclk,
   output logic                    mosi,
   output logic                    ss_n
);
   import spi_pkg::*;

   shift_state_e    state;
   logic [DIVW-1:0] div;       // clk count within a half period
   logic [BITW-1:0] bitcnt;    // Bit of the current byte
   logic [SW-1:0]   shreg;     // Current byte, MSB on mosi
   logic            div_last;
   logic            bit_last;
   logic            fall;      // sclk about to drop

   assign div_last = (div == DIVW'(CLKDIV - 1));
   assign bit_last = (bitcnt == '1);
   assign fall     = (state == SH_HIGH) & div_last;

   // Mode 0, clock idles low
   assign sclk = (state == SH_HIGH);

   // Pop from idle, or on the last fall to chain the next byte
   assign fifo_rd = ~empty & ((state == SH_IDLE) | (fall & bit_last));

   // ####################
   // Shifter FSM
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= SH_IDLE;
         div    <= '0;
         bitcnt <= '0;
         ss_n   <= 1'b1;
         mosi   <= 1'b0;
      end else begin
         case (state)
            SH_IDLE: begin
               if (fifo_rd) begin
                  state  <= SH_LOW;
                  div    <= '0;
                  bitcnt <= '0;
                  ss_n   <= 1'b0;            // Frame opens
                  mosi   <= dout[SW-1];      // First bit ahead of the rise
               end
            end
            SH_LOW: begin
               div <= div + 1'b1;
               if (div_last) begin
                  div   <= '0;
                  state <= SH_HIGH;
               end
            end
            SH_HIGH: begin
               div <= div + 1'b1;
               if (div_last) begin
                  div <= '0;
                  if (!bit_last) begin
                     bitcnt <= bitcnt + 1'b1;
                     mosi   <= shreg[SW-2];  // Next bit on the fall
                     state  <= SH_LOW;
                  end else if (fifo_rd) begin
                     bitcnt <= '0;
                     mosi   <= dout[SW-1];   // Back to back, ss_n stays low
                     state  <= SH_LOW;
                  end else begin
                     state <= SH_GAP;
                  end
               end
            end
            SH_GAP: begin
               div <= div + 1'b1;
               if (div_last) begin
                  div   <= '0;
                  ss_n  <= 1'b1;             // Release after a half period
                  mosi  <= 1'b0;
                  state <= SH_IDLE;
               end
            end
            default: state <= SH_IDLE;
         endcase
      end
   end

   // Byte register, shifts left on each fall
   always_ff @(posedge clk) begin
      if (fifo_rd) begin
         shreg <= dout;
      end else if (fall) begin
         shreg <= shreg << 1;
      end
   end

endmodule

//--- hdl/spi_tx_decode.sv
`timescale 1ns/100ps
module spi_tx_decode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  emode,      // 1 = raw packet mode
   input  logic                  access_in,
   input  spi_pkg::emesh_packet_t packet_in,
   output logic                  wait_out,
   input  logic                  busy,       // Serializer still shifting
   output logic                  job_valid,
   output spi_pkg::tx_job_t      job
);
   import spi_pkg::*;

   logic      tx_hit;      // Write to the transmit register
   logic      slot_free;   // Job register empty or being taken now
   datamode_e dm;
   tx_job_t   job_next;

   assign dm     = datamode_e'(packet_in.datamode);
   assign tx_hit = access_in & packet_in.write & (packet_in.dstaddr[5:0] == SPI_TX);

   // Full and serializer not loading -> push back
   assign wait_out  = job_valid & busy;
   assign slot_free = ~wait_out;

   // ####################
   // Job formation
   // ####################

   always_comb begin
      if (emode) begin
         job_next.payload = packet_in;           // Whole packet, LSB byte first
         job_next.count   = CNTW'(NBYTES - 1);
      end else begin
         // Data word then source address, upper bytes zero
         job_next.payload = {{(PW-2*AW){1'b0}}, packet_in.srcaddr, packet_in.data};
         case (dm)
            DM_BYTE: job_next.count = CNTW'(0);
            DM_HALF: job_next.count = CNTW'(1);
            DM_WORD: job_next.count = CNTW'(3);
            default: job_next.count = CNTW'(7);  // DM_DOUBLE
         endcase
      end
   end

   // Valid refills or clears whenever the slot frees up
   always_ff @(posedge clk) begin
      if (rst) begin
         job_valid <= 1'b0;
      end else if (slot_free) begin
         job_valid <= tx_hit;   // Non-TX accesses dropped here
      end
   end

   always_ff @(posedge clk) begin
      if (slot_free && tx_hit) begin
         job <= job_next;
      end
   end

endmodule

//--- hdl/spi_tx_fifo.sv
`timescale 1ns/100ps
module spi_tx_fifo (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr_en,
   input  logic [spi_pkg::SW-1:0]  din,
   input  logic                    rd_en,
   output logic [spi_pkg::SW-1:0]  dout,
   output logic                    empty,
   output logic                    full,
   output logic                    prog_full
);
   import spi_pkg::*;

   logic [SW-1:0]      mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_CW-1:0] count;      // Entries held
   logic               do_wr;
   logic               do_rd;

   assign empty = (count == '0);
   assign full  = (count == FIFO_CW'(FIFO_DEPTH));

   // Overflow and underflow requests are dropped
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   assign dout = mem[rd_ptr];      // Fall-through head byte

   // ####################
   // Pointers and count
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         prog_full <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Both or neither
         endcase
         prog_full <= (count >= FIFO_CW'(PROG_FULL_LEVEL));  // One cycle late, level has slack
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

//--- spi_master_tx.f
hdl/spi_pkg.sv
hdl/spi_tx_decode.sv
hdl/spi_par2ser.sv
hdl/spi_tx_fifo.sv
hdl/spi_shifter.sv
hdl/spi_master_tx.sv
verification/spi_master_tx_assert.sv
verification/spi_master_tx_tb.sv

//--- verification/spi_master_tx_assert.sv
`timescale 1ns/100ps
module spi_master_tx_assert (
   input logic                   clk,
   input logic                   rst,
   input logic                   access_in,
   input spi_pkg::emesh_packet_t packet_in,
   input logic                   wait_out,
   input logic                   sclk,
   input logic                   mosi,
   input logic                   ss_n,
   input logic                   fifo_wr,
   input logic                   fifo_rd,
   input logic                   fifo_full,
   input logic                   fifo_empty
);

   // Bus idle right out of reset
   a_reset_idle: assert property (@(posedge clk) rst |=> (ss_n && !sclk))
      else $error("ss_n or sclk not idle after reset");

   // Slave samples while sclk high
   a_mosi_stable: assert property (@(posedge clk) disable iff (rst) sclk |-> $stable(mosi))
      else $error("mosi changed while sclk high");

   a_no_overflow: assert property (@(posedge clk) disable iff (rst) fifo_wr |-> !fifo_full)
      else $error("FIFO written while full");

   // FIFO runs dry only through a pop
   a_empty_on_pop: assert property (@(posedge clk) disable iff (rst)
      $rose(fifo_empty) |-> $past(fifo_rd))
      else $error("FIFO went empty without a read");

   // Held access stays put until taken
   a_access_held: assert property (@(posedge clk) disable iff (rst)
      (access_in && wait_out) |=> (access_in && $stable(packet_in)))
      else $error("access_in or packet_in changed while wait_out high");

endmodule

bind spi_master_tx spi_master_tx_assert u_assert (
   .clk        (clk),
   .rst        (rst),
   .access_in  (access_in),
   .packet_in  (packet_in),
   .wait_out   (wait_out),
   .sclk       (sclk),
   .mosi       (mosi),
   .ss_n       (ss_n),
   .fifo_wr    (fifo_wr),
   .fifo_rd    (fifo_rd),
   .fifo_full  (fifo_full),
   .fifo_empty (fifo_empty)
);

//--- verification/spi_master_tx_tb.sv
`timescale 1ns/100ps
module spi_master_tx_tb;
   import spi_pkg::*;

   localparam int         CLK_PERIOD   = 8;
   localparam logic [5:0] TX_OFFSET    = 6'h10;   // Transmit register offset
   localparam int         RAW_BYTES    = 13;
   localparam int         BURST_PKTS   = 5;       // Eight-byte packets in the burst
   localparam int         IDLE_WINDOW  = 300;     // Cycles watched for stray traffic
   localparam int         TOTAL_BYTES  = 1 + 2 + 4 + 8 + RAW_BYTES + 8*BURST_PKTS;
   localparam int         WATCHDOG_CYC = TOTAL_BYTES*40 + 2*IDLE_WINDOW + 2000;

   logic          clk;
   logic          rst;
   logic          emode;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          sclk;
   logic          mosi;
   logic          ss_n;

   logic [7:0] model_q[$];        // Expected bytes, wire order
   logic [7:0] rx_q[$];           // Bytes seen on the bus
   logic [7:0] rx_byte   = '0;
   int         rx_bits   = 0;
   int         frames    = 0;     // Completed ss_n frames
   int         wait_seen = 0;     // Cycles an access was held off
   logic       sclk_q    = 1'b0;
   logic       ss_q      = 1'b1;

   spi_master_tx u_spi_master_tx (
      .clk       (clk),
      .rst       (rst),
      .emode     (emode),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss_n      (ss_n)
   );

   // ####################
   // Clock and watchdog
   // ####################

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYC);
      $display("SOME TESTS FAILED");
      $fatal(1, "Watchdog expired");
   end

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "Check failed");
      end
   endtask

   // ####################
   // SPI bus monitor
   // ####################

   // Sampled mid-cycle, away from the clk edge where pins move
   always @(negedge clk) begin
      if (rst) begin
         rx_bits = 0;
      end else begin
         if (sclk && !sclk_q && !ss_n) begin      // Mode 0, slave samples on the rise
            rx_byte = {rx_byte[6:0], mosi};       // MSB first
            rx_bits = rx_bits + 1;
            if (rx_bits == 8) begin
               rx_q.push_back(rx_byte);
               rx_bits = 0;
            end
         end
         if (ss_n && !ss_q) begin                  // End of frame
            frames = frames + 1;
            check_equal(rx_bits, 0, "ss_n released in the middle of a byte");
         end
         if (ss_n) check_equal(sclk, 0, "sclk active while ss_n high");
      end
      sclk_q = sclk;
      ss_q   = ss_n;
   end

   // ####################
   // Stimulus and model
   // ####################

   function automatic emesh_packet_t make_packet(input logic [5:0] offset, input logic wr,
                                                 input logic [1:0] dm);
      emesh_packet_t p;
      p.srcaddr       = $urandom;
      p.data          = $urandom;
      p.dstaddr       = $urandom;
      p.dstaddr[5:0]  = offset;
      p.ctrlmode      = 5'($urandom);
      p.datamode      = dm;
      p.write         = wr;
      return p;
   endfunction

   task automatic send_packet(input emesh_packet_t p, input logic raw);
      logic [PW-1:0] flat;
      logic [63:0]   words;
      logic          held;
      int            nbytes;
      flat  = p;
      words = {p.srcaddr, p.data};                 // Data word goes out first
      @(posedge clk);
      #1;
      emode     = raw;
      packet_in = p;
      access_in = 1'b1;
      do begin                                     // Hold until taken
         @(negedge clk);
         held = wait_out;
         if (held) wait_seen++;
         @(posedge clk);
      end while (held);
      #1;
      access_in = 1'b0;
      // Only writes to the transmit register reach the bus
      if (p.write && p.dstaddr[5:0] == TX_OFFSET) begin
         nbytes = raw ? RAW_BYTES : (1 << p.datamode);
         for (int i = 0; i < nbytes; i++) begin
            model_q.push_back(raw ? flat[8*i +: 8] : words[8*i +: 8]);
         end
      end
   endtask

   task automatic drain_and_compare(input string name);
      int idx;
      do begin
         @(negedge clk);
      end while (rx_q.size() < model_q.size() || !ss_n);
      @(posedge clk);                              // Monitor has settled
      check_equal(rx_q.size(), model_q.size(), {name, " byte count"});
      idx = 0;
      while (rx_q.size() > 0) begin
         check_equal(rx_q.pop_front(), model_q.pop_front(),
                     $sformatf("%s byte %0d", name, idx));
         idx++;
      end
      check_equal(sclk, 0, {name, " sclk idle level"});
   endtask

   // ####################
   // Tests
   // ####################

   task automatic test_data_modes();
      int frames_before;
      for (int dm = 0; dm < 4; dm++) begin
         frames_before = frames;
         send_packet(make_packet(TX_OFFSET, 1'b1, 2'(dm)), 1'b0);
         drain_and_compare($sformatf("data mode %0d", dm));
         check_equal(frames - frames_before, 1, "one ss_n frame per data-mode packet");
      end
   endtask

   task automatic test_raw_mode();
      int frames_before;
      frames_before = frames;
      send_packet(make_packet(TX_OFFSET, 1'b1, 2'($urandom)), 1'b1);
      drain_and_compare("raw mode");
      check_equal(frames - frames_before, 1, "one ss_n frame for the raw packet");
   endtask

   task automatic test_filtering();
      int frames_before;
      frames_before = frames;
      send_packet(make_packet(6'h00, 1'b1, 2'd3), 1'b0);
      send_packet(make_packet(6'h11, 1'b1, 2'd2), 1'b1);
      send_packet(make_packet(6'h30, 1'b1, 2'd1), 1'b0);
      send_packet(make_packet(TX_OFFSET, 1'b0, 2'd3), 1'b0);   // Reads of TX register
      send_packet(make_packet(TX_OFFSET, 1'b0, 2'd0), 1'b1);
      repeat (IDLE_WINDOW) begin
         @(negedge clk);
         check_equal(ss_n, 1, "ss_n fell for a dropped packet");
      end
      check_equal(rx_q.size(), 0, "bytes received from dropped packets");
      check_equal(frames - frames_before, 0, "frames from dropped packets");
   endtask

   // Burst outruns the bus, FIFO fills and stalls the serializer
   task automatic test_back_pressure();
      int frames_before;
      frames_before = frames;
      wait_seen     = 0;
      repeat (BURST_PKTS) send_packet(make_packet(TX_OFFSET, 1'b1, 2'd3), 1'b0);
      check_equal(wait_seen > 0, 1, "wait_out never rose under back-pressure");
      drain_and_compare("back-pressure");
      check_equal(frames - frames_before, 1, "ss_n held low across the burst");
   endtask

   initial begin
      void'($urandom(32'he749));
      rst       = 1'b1;
      emode     = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      test_data_modes();
      test_raw_mode();
      test_filtering();
      test_back_pressure();
      repeat (IDLE_WINDOW) @(negedge clk);   // Quiet tail, stray frames land here
      check_equal(ss_n, 1, "ss_n idle level at the end");
      if (rx_q.size() != 0 || model_q.size() != 0) begin
         $display("Bytes left over at the end: %0d received, %0d expected",
                  rx_q.size(), model_q.size());
         $display("SOME TESTS FAILED");
         $fatal(1, "Leftover bytes");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule
